//--- tb.f
playground_pkg.sv
io_write_decode.sv
io_register_file.sv
tick_timer.sv
led_modulator.sv
io_read_mux.sv
io_peripheral_top.sv
tb_clock_gen.sv
tb_io_top.sv

//--- Bender.yml
package:
  name: io_peripheral

sources:
  - playground_pkg.sv
  - io_write_decode.sv
  - io_register_file.sv
  - tick_timer.sv
  - led_modulator.sv
  - io_read_mux.sv
  - io_peripheral_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_io_top.sv

//--- tb_io_top.sv
// Random register traffic from seed 7709 against a model; two full duty windows set the run length
`timescale 1ns/1ps

module tb_io_top;

   import playground_pkg::*;

   localparam int SDM_WINDOW      = 1 << SDM_WIDTH;  // Cycles in one duty window
   localparam int SDM_RUNS        = 2;
   localparam int RW_WRITES       = 200;
   localparam int WATCHDOG_CYCLES = (SDM_RUNS + 2) * SDM_WINDOW + 4096;

   logic        clk;
   logic        reset_button;
   io_bus_t     bus;
   logic [7:0]  gpio_in;
   logic [31:0] rdata;
   logic [7:0]  gpio_out;
   logic [7:0]  gpio_dir;
   logic [2:0]  led_pwm;
   logic        interrupt;

   integer seed;
   int     checks;
   int     test_errors;
   int     total_errors;
   int     tests_run;

   // Model of the software registers
   logic [7:0]  m_out;
   logic [7:0]  m_dir;
   logic [31:0] m_scratch;
   logic [3:0]  m_leds;
   logic [15:0] m_lvl [3];                     // Red, green, blue
   logic [31:0] m_reload;

   logic [3:0] legal_masks [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
   int         reg_list [7]    = '{SEL_GPIO, SEL_SCRATCH, SEL_LEDS, SEL_SDM_RED,
                                   SEL_SDM_GREEN, SEL_SDM_BLUE, SEL_RELOAD};

   tb_clock_gen #(.HALF_PERIOD(2), .RESET_CYCLES(16)) u_clock
   (
      .clk          (clk),
      .reset_button (reset_button)
   );

   io_peripheral_top #(.SDM_BITS(SDM_WIDTH), .TIMER_BITS(DATA_WIDTH)) DUT
   (
      .clk          (clk),
      .reset_button (reset_button),
      .bus          (bus),
      .gpio_in      (gpio_in),
      .rdata        (rdata),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led_pwm      (led_pwm),
      .interrupt    (interrupt)
   );

   // Address: IO nibble, one-hot select bit, operation in bits 3:2
   function automatic logic [31:0] io_addr(input int sel, input io_op_t op);
      return {IO_REGION, 28'h0} | (32'h1 << sel) | {28'h0, op, 2'b00};
   endfunction

   function automatic logic [31:0] model_word(input int sel);
      case (sel)
         SEL_GPIO:      return {8'h00, m_dir, m_out, gpio_in};
         SEL_SCRATCH:   return m_scratch;
         SEL_FEEDBACK:  return m_scratch ^ (m_scratch >> 1);
         SEL_LEDS:      return {28'h0, m_leds};
         SEL_SDM_RED:   return {16'h0, m_lvl[0]};
         SEL_SDM_GREEN: return {16'h0, m_lvl[1]};
         SEL_SDM_BLUE:  return {16'h0, m_lvl[2]};
         SEL_RELOAD:    return m_reload;
         default:       return '0;       // Ticks not modelled
      endcase
   endfunction

   task automatic apply_model(input int sel, input io_op_t op, input logic [31:0] data,
                              input logic [3:0] mask);
      logic [31:0] cur;
      logic [31:0] value;
      cur = model_word(sel);
      case (op)
         OP_CLEAR:  value = cur & ~data;
         OP_SET:    value = cur | data;
         OP_TOGGLE: value = cur ^ data;
         default:   value = data;
      endcase
      if (sel == SEL_GPIO && mask[1])
         m_out = value[15:8];                  // Output in byte 1
      if (sel == SEL_GPIO && mask[2])
         m_dir = value[23:16];                 // Direction in byte 2
      for (int b = 0; b < 4; b++)
         if (sel == SEL_SCRATCH && mask[b])
            m_scratch[8*b +: 8] = value[8*b +: 8];
      if (sel == SEL_LEDS)
         m_leds = value[3:0];
      for (int c = 0; c < 3; c++)
         if (sel == SEL_SDM_RED + c)
            m_lvl[c] = value[15:0];            // Word-only, mask ignored
      if (sel == SEL_RELOAD)
         m_reload = value;
   endtask

   task automatic write_reg(input int sel, input io_op_t op, input logic [31:0] data,
                            input logic [3:0] mask);
      apply_model(sel, op, data, mask);
      @(posedge clk);
      bus <= '{address: io_addr(sel, op), wdata: data, wmask: mask, rstrb: 1'b0};
      @(posedge clk);                          // Write edge
      bus <= '0;
   endtask

   task automatic read_reg(input int sel, output logic [31:0] val);
      @(posedge clk);
      bus <= '{address: io_addr(sel, OP_WRITE), wdata: '0, wmask: 4'h0, rstrb: 1'b1};
      @(posedge clk);                          // rdata loads here
      bus <= '0;
      @(negedge clk);
      val = rdata;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_reg(input int sel);
      logic [31:0] got;
      read_reg(sel, got);
      check_value($sformatf("rdata (select bit %0d)", sel), got, model_word(sel));
   endtask

   // Counts edges until interrupt is seen high between edges
   task automatic count_to_interrupt(input int limit, output int edges);
      edges = 0;
      do
      begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      while (interrupt !== 1'b1 && edges < limit);
      checks++;
      assert (interrupt === 1'b1)
      else
      begin
         $display("Timer interrupt did not arrive within %0d cycles", limit);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("Test %0d %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "passed" : "failed", test_errors);
      total_errors += test_errors;
      test_errors = 0;
   endtask

   initial
   begin
      int          sel;
      io_op_t      op;
      logic [31:0] data;
      logic [3:0]  mask;
      int          m_ticks;
      int          n_ticks;
      int          edges;
      logic [15:0] lv [3];
      int          ones [3];
      int          ch;
      int          high;

      bus = '0;
      gpio_in = '0;
      seed = 32'h7709;
      checks = 0;
      test_errors = 0;
      total_errors = 0;
      tests_run = 0;
      m_out = '0;
      m_dir = '0;
      m_scratch = '0;
      m_leds = '0;
      m_lvl = '{default: '0};
      m_reload = '0;

      wait (reset_button === 1'b0);
      @(negedge clk);
      check_value("gpio_out", gpio_out, '0);
      check_value("gpio_dir", gpio_dir, '0);
      check_value("led_pwm", led_pwm, '0);
      check_value("interrupt", interrupt, '0);
      check_value("rdata", rdata, '0);
      for (int i = 0; i < 7; i++)
         check_reg(reg_list[i]);
      end_test("reset values");

      @(posedge clk);
      gpio_in <= $random(seed);                // Held through the random writes
      @(negedge clk);
      for (int i = 0; i < RW_WRITES; i++)
      begin
         sel  = reg_list[$unsigned($random(seed)) % 6];
         data = $random(seed);
         op   = io_op_t'(data[1:0]);
         data = $random(seed);
         mask = legal_masks[$unsigned($random(seed)) % 7];
         write_reg(sel, op, data, mask);
         @(negedge clk);
         check_value("gpio_out", gpio_out, m_out);
         check_value("gpio_dir", gpio_dir, m_dir);
         check_reg(sel);
      end
      end_test("random writes and readback");

      for (int i = 0; i < 16; i++)
      begin
         write_reg(SEL_SCRATCH, OP_WRITE, $random(seed), 4'b1111);
         check_reg(SEL_FEEDBACK);
         @(posedge clk);
         gpio_in <= $random(seed);
         check_reg(SEL_GPIO);                  // Pins in the low byte
      end
      end_test("feedback and GPIO word");

      m_ticks = 20 + $unsigned($random(seed)) % 80;
      n_ticks = 20 + $unsigned($random(seed)) % 80;
      write_reg(SEL_RELOAD, OP_WRITE, -m_ticks, 4'b1111);
      write_reg(SEL_TICKS, OP_WRITE, -n_ticks, 4'b1111);
      count_to_interrupt(n_ticks + 16, edges);
      check_value("interrupt delay", edges, n_ticks);
      @(posedge clk);
      @(negedge clk);
      check_value("interrupt", interrupt, 1'b0);  // Pulse is one cycle
      count_to_interrupt(m_ticks + 16, edges);
      check_value("interrupt period", edges, m_ticks - 1);
      check_reg(SEL_RELOAD);
      end_test("timer interrupt");

      write_reg(SEL_LEDS, OP_WRITE, '0, 4'b1111);
      for (int w = 0; w < SDM_RUNS; w++)
      begin
         for (int c = 0; c < 3; c++)
         begin
            lv[c] = $random(seed);
            write_reg(SEL_SDM_RED + c, OP_WRITE, lv[c], 4'b0011);
         end
         @(posedge clk);
         @(posedge clk);                       // Carry now from the new levels
         ones = '{default: 0};
         repeat (SDM_WINDOW)
         begin
            @(negedge clk);
            for (int c = 0; c < 3; c++)
               ones[c] += led_pwm[c];
         end
         for (int c = 0; c < 3; c++)
            check_value($sformatf("led_pwm[%0d] ones", c), ones[c], lv[c]);
      end
      ch = $unsigned($random(seed)) % 3;
      write_reg(SEL_LEDS, OP_SET, 32'h1 << ch, 4'b1111);
      high = 0;
      repeat (1024)
      begin
         @(negedge clk);
         high += led_pwm[ch];
      end
      check_value($sformatf("led_pwm[%0d] high cycles", ch), high, 1024);
      end_test("sigma-delta duty");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
      if (total_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // Limit covers the duty windows plus the short tests with margin
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog stopped the run after %0d cycles, the tests did not finish",
               WATCHDOG_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- tb_clock_gen.sv
// Clock runs from time zero; reset_button starts high and drops on a rising edge after RESET_CYCLES
`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter int HALF_PERIOD  = 2,             // ns, so a 4 ns period
   parameter int RESET_CYCLES = 16
)
(
   output logic clk,
   output logic reset_button
);

   initial
   begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial
   begin
      reset_button = 1'b1;                     // Held from time zero
      repeat (RESET_CYCLES) @(posedge clk);
      reset_button <= 1'b0;                    // Synchronous release
   end

endmodule

//--- io_peripheral_top.sv
// IO block only: no busy outputs and no back-pressure, one access per cycle; TIMER_BITS up to 32
`timescale 1ns/1ps

module io_peripheral_top
#(
   parameter int SDM_BITS   = playground_pkg::SDM_WIDTH,
   parameter int TIMER_BITS = playground_pkg::DATA_WIDTH
)
(
   input  logic                    clk,
   input  logic                    reset_button,
   input  playground_pkg::io_bus_t bus,
   input  logic [7:0]              gpio_in,
   output logic [31:0]             rdata,
   output logic [7:0]              gpio_out,
   output logic [7:0]              gpio_dir,
   output logic [2:0]              led_pwm,
   output logic                    interrupt
);

   import playground_pkg::*;

   io_write_t             wr;
   logic                  rd_strb;
   logic [23:0]           rd_sel;
   logic [31:0]           cur;                 // Read word fed back for RMW
   logic [31:0]           scratch;
   logic [31:0]           gpio_word;
   logic [3:0]            leds;
   sdm_level_t            levels;
   logic [TIMER_BITS-1:0] ticks;
   logic [TIMER_BITS-1:0] reload;

   io_write_decode u_decode
   (
      .clk     (clk),
      .bus     (bus),
      .cur     (cur),
      .wr      (wr),
      .rd_strb (rd_strb),
      .rd_sel  (rd_sel)
   );

   io_register_file u_regs
   (
      .clk          (clk),
      .reset_button (reset_button),
      .wr           (wr),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .scratch      (scratch),
      .leds         (leds),
      .levels       (levels),
      .gpio_word    (gpio_word)
   );

   tick_timer #(.WIDTH(TIMER_BITS)) u_timer
   (
      .clk          (clk),
      .reset_button (reset_button),
      .wr           (wr),
      .ticks        (ticks),
      .reload       (reload),
      .interrupt    (interrupt)
   );

   led_modulator #(.WIDTH(SDM_BITS)) u_sdm
   (
      .clk          (clk),
      .reset_button (reset_button),
      .levels       (levels),
      .force_on     (leds[2:0]),               // Red, green, blue from bit 0 up
      .led_pwm      (led_pwm)
   );

   io_read_mux u_rmux
   (
      .clk          (clk),
      .reset_button (reset_button),
      .rd_strb      (rd_strb),
      .rd_sel       (rd_sel),
      .gpio_word    (gpio_word),
      .scratch      (scratch),
      .leds         (leds),
      .levels       (levels),
      .ticks        (DATA_WIDTH'(ticks)),      // Zero-extended narrow timer
      .reload       (DATA_WIDTH'(reload)),
      .cur          (cur),
      .rdata        (rdata)
   );

endmodule

//--- io_read_mux.sv
// Selects OR together, so several select bits read as the OR of their words; rdata is valid the cycle after the strobe
`timescale 1ns/1ps

module io_read_mux
(
   input  logic                       clk,
   input  logic                       reset_button,
   input  logic                       rd_strb,
   input  logic [23:0]                rd_sel,
   input  logic [31:0]                gpio_word,
   input  logic [31:0]                scratch,
   input  logic [3:0]                 leds,
   input  playground_pkg::sdm_level_t levels,
   input  logic [31:0]                ticks,
   input  logic [31:0]                reload,
   output logic [31:0]                cur,     // Live word, also for read-modify-write
   output logic [31:0]                rdata    // Held until the next IO read
);

   import playground_pkg::*;

   logic [31:0] feedback;

   assign feedback = scratch ^ (scratch >> 1); // Neighbour-bit XOR

   // One-hot OR mux, unselected words contribute zero
   always_comb
   begin
      cur = '0;
      if (rd_sel[SEL_GPIO      - SEL_BASE]) cur |= gpio_word;
      if (rd_sel[SEL_SCRATCH   - SEL_BASE]) cur |= scratch;
      if (rd_sel[SEL_FEEDBACK  - SEL_BASE]) cur |= feedback;  // Read only
      if (rd_sel[SEL_LEDS      - SEL_BASE]) cur |= DATA_WIDTH'(leds);
      if (rd_sel[SEL_SDM_RED   - SEL_BASE]) cur |= DATA_WIDTH'(levels.red);
      if (rd_sel[SEL_SDM_GREEN - SEL_BASE]) cur |= DATA_WIDTH'(levels.green);
      if (rd_sel[SEL_SDM_BLUE  - SEL_BASE]) cur |= DATA_WIDTH'(levels.blue);
      if (rd_sel[SEL_TICKS     - SEL_BASE]) cur |= ticks;
      if (rd_sel[SEL_RELOAD    - SEL_BASE]) cur |= reload;
   end

   // Sample on the strobe edge; the processor picks it up one cycle later
   always_ff @(posedge clk)
   begin
      if (reset_button)
         rdata <= '0;
      else if (rd_strb)
         rdata <= cur;
   end

   // Every IO read names at least one register
   assert property (@(posedge clk) disable iff (reset_button)
      rd_strb |-> rd_sel != '0)
      else $error("io_read_mux: IO read with no register selected");

endmodule

//--- led_modulator.sv
// First-order sigma-delta per colour; WIDTH must not exceed SDM_WIDTH, higher level bits are dropped
`timescale 1ns/1ps

module led_modulator
#(
   parameter int WIDTH = playground_pkg::SDM_WIDTH
)
(
   input  logic                       clk,
   input  logic                       reset_button,
   input  playground_pkg::sdm_level_t levels,
   input  logic [2:0]                 force_on, // [0] red, [1] green, [2] blue
   output logic [2:0]                 led_pwm
);

   import playground_pkg::*;

   logic [WIDTH-1:0] level [3];                // Same order as force_on
   logic [WIDTH-1:0] phase [3];                // Accumulators
   logic [2:0]       carry;                    // Registered overflow, the pulse train

   assign level[0] = levels.red[WIDTH-1:0];
   assign level[1] = levels.green[WIDTH-1:0];
   assign level[2] = levels.blue[WIDTH-1:0];

   // Each period of 2^WIDTH edges overflows exactly level times
   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         carry <= '0;
         for (int i = 0; i < 3; i++)
            phase[i] <= '0;                    // Window starts at phase zero
      end
      else
      begin
         for (int i = 0; i < 3; i++)
            {carry[i], phase[i]} <= {1'b0, phase[i]} + {1'b0, level[i]};
      end
   end

   // LED bit forces the channel fully on
   assign led_pwm = carry | force_on;

endmodule

//--- tick_timer.sv
// WIDTH up to 32; a write on the wrap edge still raises the interrupt, and an all-ones reload fires every cycle
`timescale 1ns/1ps

module tick_timer
#(
   parameter int WIDTH = 32
)
(
   input  logic                      clk,
   input  logic                      reset_button,
   input  playground_pkg::io_write_t wr,
   output logic [WIDTH-1:0]          ticks,
   output logic [WIDTH-1:0]          reload,
   output logic                      interrupt
);

   import playground_pkg::*;

   logic [WIDTH:0] ticks_plus_1;               // Carry out marks the wrap
   logic           wr_ticks;
   logic           wr_reload;

   assign ticks_plus_1 = {1'b0, ticks} + 1'b1;
   assign wr_ticks     = wr.wstrb & wr.sel[SEL_TICKS  - SEL_BASE];
   assign wr_reload    = wr.wstrb & wr.sel[SEL_RELOAD - SEL_BASE];

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         ticks     <= '0;
         reload    <= '0;
         interrupt <= 1'b0;
      end
      else
      begin
         if (wr_ticks)
            ticks <= wr.value[WIDTH-1:0];      // Software count wins over counting
         else if (ticks_plus_1[WIDTH])
            ticks <= reload;                   // Wrap, restart from reload
         else
            ticks <= ticks_plus_1[WIDTH-1:0];

         if (wr_reload)
            reload <= wr.value[WIDTH-1:0];

         interrupt <= ticks_plus_1[WIDTH];     // One-cycle pulse on overflow
      end
   end

   // Pulse only after an all-ones count, and the count restarts from reload unless written
   assert property (@(posedge clk) disable iff (reset_button)
      interrupt |-> $past(&ticks) && ($past(wr_ticks) || ticks == $past(reload)))
      else $error("tick_timer: interrupt without a wrap to reload");

endmodule

//--- io_register_file.sv
// GPIO and scratch honour byte lanes; LEDs and levels take the whole modified word whatever the mask
`timescale 1ns/1ps

module io_register_file
(
   input  logic                       clk,
   input  logic                       reset_button,
   input  playground_pkg::io_write_t  wr,
   input  logic [7:0]                 gpio_in,
   output logic [7:0]                 gpio_out,
   output logic [7:0]                 gpio_dir,
   output logic [31:0]                scratch,
   output logic [3:0]                 leds,
   output playground_pkg::sdm_level_t levels,
   output logic [31:0]                gpio_word
);

   import playground_pkg::*;

   logic sel_gpio;
   logic sel_scratch;
   logic sel_leds;
   logic sel_red;
   logic sel_green;
   logic sel_blue;

   // Qualified selects
   assign sel_gpio    = wr.wstrb & wr.sel[SEL_GPIO      - SEL_BASE];
   assign sel_scratch = wr.wstrb & wr.sel[SEL_SCRATCH   - SEL_BASE];
   assign sel_leds    = wr.wstrb & wr.sel[SEL_LEDS      - SEL_BASE];
   assign sel_red     = wr.wstrb & wr.sel[SEL_SDM_RED   - SEL_BASE];
   assign sel_green   = wr.wstrb & wr.sel[SEL_SDM_GREEN - SEL_BASE];
   assign sel_blue    = wr.wstrb & wr.sel[SEL_SDM_BLUE  - SEL_BASE];

   // Port word as software sees it
   assign gpio_word = {8'h00, gpio_dir, gpio_out, gpio_in};

   // Byte-lane registers
   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         gpio_out <= '0;                       // All pins inputs after reset
         gpio_dir <= '0;
         scratch  <= '0;
      end
      else
      begin
         // GPIO lanes: byte 1 output, byte 2 direction
         if (sel_gpio & wr.wmask[1])
            gpio_out <= wr.value[15:8];
         if (sel_gpio & wr.wmask[2])
            gpio_dir <= wr.value[23:16];

         // Scratch, each lane on its own mask bit
         for (int b = 0; b < 4; b++)
         begin
            if (sel_scratch & wr.wmask[b])
               scratch[8*b +: 8] <= wr.value[8*b +: 8];
         end
      end
   end

   // Word-only registers
   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         leds   <= '0;
         levels <= '0;                         // Modulators dark
      end
      else
      begin
         if (sel_leds)
            leds <= wr.value[3:0];             // Upper bits dropped
         if (sel_red)
            levels.red <= wr.value[SDM_WIDTH-1:0];
         if (sel_green)
            levels.green <= wr.value[SDM_WIDTH-1:0];
         if (sel_blue)
            levels.blue <= wr.value[SDM_WIDTH-1:0];
      end
   end

endmodule

//--- io_write_decode.sv
// Combinational only; cur must be the read word of the same address, or clear/set/toggle go wrong
`timescale 1ns/1ps

module io_write_decode
(
   input  logic                      clk,
   input  playground_pkg::io_bus_t   bus,
   input  logic [31:0]               cur,      // Read word for read-modify-write
   output playground_pkg::io_write_t wr,
   output logic                      rd_strb,
   output logic [23:0]               rd_sel
);

   import playground_pkg::*;

   logic   is_io;                              // Top nibble hits the IO block
   io_op_t op;

   assign is_io = (bus.address[31:28] == IO_REGION);
   assign op    = io_op_t'(bus.address[3:2]); // Write +0, clear +4, set +8, toggle +12

   // Read side needs no op, only the selects
   assign rd_strb = is_io & bus.rstrb;
   assign rd_sel  = bus.address[27:4];

   always_comb
   begin
      wr.wstrb = is_io & (|bus.wmask);
      wr.sel   = bus.address[27:4];            // Several bits set write all of them
      wr.wmask = bus.wmask;
      wr.raw   = bus.wdata;

      // Atomic bit operations on the current contents
      case (op)
         OP_CLEAR:  wr.value = cur & ~wr.raw;
         OP_SET:    wr.value = cur |  wr.raw;
         OP_TOGGLE: wr.value = cur ^  wr.raw;
         default:   wr.value = wr.raw;        // OP_WRITE
      endcase
   end

   // Processor only issues aligned byte, half-word or word stores
   assert property (@(posedge clk)
      wr.wstrb |-> wr.wmask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b0011, 4'b1100, 4'b1111})
      else $error("io_write_decode: illegal IO write mask %b", wr.wmask);

endmodule

//--- playground_pkg.sv
// IO bus types and register map; select constants are address bit numbers, and the one-hot field starts at address bit 4
package playground_pkg;

   localparam int DATA_WIDTH = 32;             // Bus word
   localparam int SDM_WIDTH  = 16;             // Brightness level width

   localparam logic [3:0] IO_REGION = 4'h4;    // address[31:28] of the IO block

   // One-hot register selects, as address bit numbers
   localparam int SEL_BASE      = 4;           // Lowest select bit, sel[0]
   localparam int SEL_GPIO      = 4;           // RW  dir, out, in
   localparam int SEL_SCRATCH   = 5;           // RW  byte-lane scratch
   localparam int SEL_FEEDBACK  = 6;           // RO  scratch feedback
   localparam int SEL_LEDS      = 8;           // RW  LED bits
   localparam int SEL_SDM_RED   = 9;           // RW  red level
   localparam int SEL_SDM_GREEN = 10;          // RW  green level
   localparam int SEL_SDM_BLUE  = 11;          // RW  blue level
   localparam int SEL_TICKS     = 18;          // RW  timer count
   localparam int SEL_RELOAD    = 19;          // RW  timer reload

   // Write operation, address bits 3:2
   typedef enum logic [1:0]
   {
      OP_WRITE  = 2'd0,                        // Plain store
      OP_CLEAR  = 2'd1,                        // Current AND NOT data
      OP_SET    = 2'd2,                        // Current OR data
      OP_TOGGLE = 2'd3                         // Current XOR data
   } io_op_t;

   // Processor side of the bus
   typedef struct packed
   {
      logic [DATA_WIDTH-1:0] address;
      logic [DATA_WIDTH-1:0] wdata;
      logic [3:0]            wmask;            // Nonzero means write
      logic                  rstrb;
   } io_bus_t;

   // Decoded write, shared by the register file and the timer
   typedef struct packed
   {
      logic                  wstrb;            // IO write this cycle
      logic [23:0]           sel;              // address[27:4]
      logic [3:0]            wmask;
      logic [DATA_WIDTH-1:0] value;            // After clear, set or toggle
      logic [DATA_WIDTH-1:0] raw;              // Bus wdata as sent
   } io_write_t;

   // Brightness per colour
   typedef struct packed
   {
      logic [SDM_WIDTH-1:0] red;
      logic [SDM_WIDTH-1:0] green;
      logic [SDM_WIDTH-1:0] blue;
   } sdm_level_t;

endpackage
